// ==== verilog/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

	localparam int word_width = 16;
	localparam int num_alu_rs = 3;

	typedef logic [word_width-1:0] word_t;
	typedef logic [2:0] rob_tag_t;   // Also the CDB tag
	typedef logic [2:0] reg_idx_t;
	typedef logic [1:0] station_id_t;

	localparam reg_idx_t link_reg = 3'd7;  // JSR/JSRR return address

	// LC-3b opcode map
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_t;

	// Register form; low bits double as imm5 and offset6
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t dr;
		reg_idx_t sr1;
		logic imm_flag;
		logic [1:0] unused;
		reg_idx_t sr2;
	} reg_form_t;

	// PC-relative form, offset9 is pc_offset[8:0]
	typedef struct packed {
		opcode_t opcode;
		logic link;
		logic [10:0] pc_offset;
	} pc_form_t;

	typedef union packed {
		reg_form_t r;
		pc_form_t p;
	} instr_t;

endpackage

`default_nettype wire

// ==== verilog/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select
(
	input wire issue_pkg::instr_t instr,
	input wire logic sr1_busy,
	input wire logic sr2_busy,
	input wire issue_pkg::word_t sr1_data,
	input wire issue_pkg::word_t sr2_data,
	input wire issue_pkg::rob_tag_t sr1_rob_entry,
	input wire issue_pkg::rob_tag_t sr2_rob_entry,
	input wire issue_pkg::word_t rob_sr1_value,
	input wire issue_pkg::word_t rob_sr2_value,
	input wire logic rob_sr1_valid,
	input wire logic rob_sr2_valid,
	input wire logic cdb_valid,
	input wire issue_pkg::rob_tag_t cdb_tag,
	input wire issue_pkg::word_t cdb_data,
	output issue_pkg::reg_idx_t sr1,
	output issue_pkg::reg_idx_t sr2,
	output issue_pkg::word_t op_a_value,
	output issue_pkg::word_t op_b_value,
	output logic op_a_ready,
	output logic op_b_ready,
	output issue_pkg::rob_tag_t op_a_tag,
	output issue_pkg::rob_tag_t op_b_tag
);
	import issue_pkg::*;

	logic is_store;

	// Register file, then CDB forward, then ROB, else wait on the entry
	function automatic void resolve(
		input logic busy,
		input word_t rf_data,
		input rob_tag_t entry,
		input word_t rob_value,
		input logic rob_valid,
		output word_t value,
		output logic ready,
		output rob_tag_t tag
	);
		value = '0;
		ready = 1'b1;
		tag = '0;
		if (!busy)
			value = rf_data;
		else if (cdb_valid && cdb_tag == entry)
			value = cdb_data;
		else if (rob_valid)
			value = rob_value;
		else
		begin
			ready = 1'b0;
			tag = entry;
		end
	endfunction

	assign is_store = (instr.r.opcode == op_str) || (instr.r.opcode == op_stb);

	assign sr1 = instr.r.sr1;
	assign sr2 = is_store ? instr.r.dr : instr.r.sr2;  // Store data sits in dr

	always_comb
	begin
		resolve(sr1_busy, sr1_data, sr1_rob_entry, rob_sr1_value, rob_sr1_valid,
			op_a_value, op_a_ready, op_a_tag);
		resolve(sr2_busy, sr2_data, sr2_rob_entry, rob_sr2_value, rob_sr2_valid,
			op_b_value, op_b_ready, op_b_tag);
	end

endmodule

`default_nettype wire

// ==== verilog/branch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_control
(
	input wire logic clk,
	input wire logic rst_n,
	input wire issue_pkg::instr_t instr,
	input wire issue_pkg::word_t curr_pc,
	input wire logic predict_bit,
	input wire logic btb_hit,
	input wire logic btb_predict,
	input wire logic pcmux_sel,
	output logic mispredict,
	output issue_pkg::word_t pc_target,
	output logic bubble
);
	import issue_pkg::*;

	word_t off9_adj;
	word_t off11_adj;
	word_t offset;

	// Word-aligned offsets
	assign off9_adj = {{6{instr.p.pc_offset[8]}}, instr.p.pc_offset[8:0], 1'b0};
	assign off11_adj = {{4{instr.p.pc_offset[10]}}, instr.p.pc_offset, 1'b0};

	assign offset = (instr.p.opcode == op_jsr) ? off11_adj : off9_adj;
	assign pc_target = curr_pc + offset;

	// Without a BTB entry the fetch path assumed not taken
	always_comb
	begin
		if (btb_hit)
			mispredict = (predict_bit != btb_predict);
		else
			mispredict = predict_bit;
	end

	// Squash the instruction fetched behind a redirect
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bubble <= 1'b0;
		else
			bubble <= pcmux_sel;  // pcmux_sel is low during the bubble
	end

endmodule

`default_nettype wire

// ==== verilog/issue_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch
(
	input wire issue_pkg::instr_t instr,
	input wire logic instr_is_new,
	input wire logic bubble,
	input wire logic mispredict,
	input wire issue_pkg::word_t pc_target,
	input wire issue_pkg::word_t curr_pc,
	input wire issue_pkg::word_t op_a_value,
	input wire issue_pkg::word_t op_b_value,
	input wire logic op_a_ready,
	input wire logic op_b_ready,
	input wire issue_pkg::rob_tag_t op_a_tag,
	input wire issue_pkg::rob_tag_t op_b_tag,
	input wire logic predict_bit,
	input wire logic rob_full,
	input wire logic ldstr_full,
	input wire logic [issue_pkg::num_alu_rs-1:0] alu_rs_busy,
	input wire issue_pkg::rob_tag_t rob_addr,
	output logic stall,
	output logic pcmux_sel,
	output issue_pkg::word_t br_pc,
	output issue_pkg::opcode_t res_op,
	output issue_pkg::word_t res_vj,
	output issue_pkg::word_t res_vk,
	output issue_pkg::rob_tag_t res_qj,
	output issue_pkg::rob_tag_t res_qk,
	output logic issue_ld_busy_dest,
	output logic issue_ld_vj,
	output logic issue_ld_vk,
	output logic issue_ld_qj,
	output logic issue_ld_qk,
	output issue_pkg::station_id_t res_station_id,
	output logic ldstr_write_enable,
	output issue_pkg::word_t ldstr_offset,
	output issue_pkg::rob_tag_t ldstr_qsrc,
	output issue_pkg::rob_tag_t ldstr_qbase,
	output issue_pkg::rob_tag_t ldstr_dest,
	output logic ldstr_vsrc_valid,
	output logic ldstr_vbase_valid,
	output issue_pkg::word_t ldstr_vsrc,
	output issue_pkg::word_t ldstr_vbase,
	output logic rob_write_enable,
	output issue_pkg::opcode_t rob_opcode,
	output issue_pkg::reg_idx_t rob_dest,
	output issue_pkg::word_t rob_value,
	output issue_pkg::reg_idx_t reg_dest,
	output logic ld_reg_busy_dest,
	output issue_pkg::rob_tag_t reg_rob_entry
);
	import issue_pkg::*;

	opcode_t opcode;
	logic is_alu;
	logic is_ldst;
	logic needs_base;
	logic issue;
	word_t imm5_sext;
	word_t br_offset;

	assign opcode = instr.r.opcode;
	assign is_alu = opcode inside {op_add, op_and, op_not, op_shf};
	assign is_ldst = opcode inside {op_ldr, op_ldb, op_str, op_stb};
	assign needs_base = (opcode == op_jmp) || (opcode == op_jsr && !instr.p.link);  // JMP, JSRR

	assign imm5_sext = {{11{instr[4]}}, instr[4:0]};
	assign br_offset = {{6{instr.p.pc_offset[8]}}, instr.p.pc_offset[8:0], 1'b0};

	// Structural and operand hazards, held upstream until they clear
	assign stall = instr_is_new && !bubble && (rob_full ||
		(is_alu && (&alu_rs_busy)) ||
		(is_ldst && ldstr_full) ||
		(needs_base && !op_a_ready));
	assign issue = instr_is_new && !bubble && !stall;

	assign rob_opcode = opcode;
	assign res_op = opcode;

	// Lowest numbered free station wins
	always_comb
	begin
		res_station_id = '0;
		for (int i = num_alu_rs - 1; i >= 0; i--)
			if (!alu_rs_busy[i])
				res_station_id = station_id_t'(i);
	end

	always_comb
	begin
		case (opcode)
			op_ldb, op_stb: ldstr_offset = {{10{instr[5]}}, instr[5:0]};
			op_ldr, op_str: ldstr_offset = {{9{instr[5]}}, instr[5:0], 1'b0};
			default: ldstr_offset = '0;
		endcase
	end

	always_comb
	begin
		pcmux_sel = 1'b0;
		br_pc = '0;
		res_vj = '0;
		res_vk = '0;
		res_qj = '0;
		res_qk = '0;
		issue_ld_busy_dest = 1'b0;
		issue_ld_vj = 1'b0;
		issue_ld_vk = 1'b0;
		issue_ld_qj = 1'b0;
		issue_ld_qk = 1'b0;
		ldstr_write_enable = 1'b0;
		ldstr_qsrc = '0;
		ldstr_qbase = '0;
		ldstr_dest = '0;
		ldstr_vsrc_valid = 1'b0;
		ldstr_vbase_valid = 1'b0;
		ldstr_vsrc = '0;
		ldstr_vbase = '0;
		rob_write_enable = 1'b0;
		rob_dest = '0;
		rob_value = '0;
		reg_dest = '0;
		ld_reg_busy_dest = 1'b0;
		reg_rob_entry = '0;

		if (issue)
		begin
			case (opcode)
				op_add, op_and, op_not, op_shf:
				begin
					issue_ld_busy_dest = 1'b1;
					res_vj = op_a_value;
					res_qj = op_a_tag;
					issue_ld_vj = op_a_ready;
					issue_ld_qj = !op_a_ready;
					if (instr.r.imm_flag || opcode == op_shf)
					begin
						res_vk = imm5_sext;
						issue_ld_vk = 1'b1;
					end
					else
					begin
						res_vk = op_b_value;
						res_qk = op_b_tag;
						issue_ld_vk = op_b_ready;
						issue_ld_qk = !op_b_ready;
					end
				end
				op_ldr, op_ldb, op_str, op_stb:
				begin
					ldstr_write_enable = 1'b1;
					ldstr_vbase = op_a_value;  // Base from sr1
					ldstr_vbase_valid = op_a_ready;
					ldstr_qbase = op_a_tag;
					if (opcode == op_str || opcode == op_stb)
					begin
						ldstr_vsrc = op_b_value;
						ldstr_vsrc_valid = op_b_ready;
						ldstr_qsrc = op_b_tag;
					end
					else
						ldstr_dest = rob_addr;
				end
				op_br:
				begin
					rob_value = br_offset;
					br_pc = predict_bit ? pc_target : curr_pc;
					pcmux_sel = mispredict;
				end
				op_jmp:
				begin
					pcmux_sel = 1'b1;
					br_pc = op_a_value;
				end
				op_jsr:
				begin
					pcmux_sel = 1'b1;
					br_pc = instr.p.link ? pc_target : op_a_value;
					rob_value = curr_pc;  // Return address for R7
				end
				default: ;
			endcase

			// ROB and rename bookkeeping
			if (is_alu || is_ldst || opcode == op_br || opcode == op_jsr)
				rob_write_enable = 1'b1;
			if (is_alu || opcode == op_ldr || opcode == op_ldb || opcode == op_br)
				rob_dest = instr.r.dr;
			else if (opcode == op_jsr)
				rob_dest = link_reg;
			if (is_alu || opcode == op_ldr || opcode == op_ldb || opcode == op_jsr)
			begin
				reg_dest = (opcode == op_jsr) ? link_reg : instr.r.dr;
				ld_reg_busy_dest = 1'b1;
				reg_rob_entry = rob_addr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control
(
	input wire logic clk,
	input wire logic rst_n,
	input wire issue_pkg::instr_t instr,
	input wire logic instr_is_new,
	input wire issue_pkg::word_t curr_pc,
	input wire logic predict_bit,
	input wire logic btb_hit,
	input wire logic btb_predict,
	input wire logic sr1_busy,
	input wire logic sr2_busy,
	input wire issue_pkg::word_t sr1_data,
	input wire issue_pkg::word_t sr2_data,
	input wire issue_pkg::rob_tag_t sr1_rob_entry,
	input wire issue_pkg::rob_tag_t sr2_rob_entry,
	input wire issue_pkg::word_t rob_sr1_value,
	input wire issue_pkg::word_t rob_sr2_value,
	input wire logic rob_sr1_valid,
	input wire logic rob_sr2_valid,
	input wire logic cdb_valid,
	input wire issue_pkg::rob_tag_t cdb_tag,
	input wire issue_pkg::word_t cdb_data,
	input wire logic rob_full,
	input wire logic ldstr_full,
	input wire logic [issue_pkg::num_alu_rs-1:0] alu_rs_busy,
	input wire issue_pkg::rob_tag_t rob_addr,
	output logic stall,
	output logic pcmux_sel,
	output issue_pkg::word_t br_pc,
	output issue_pkg::opcode_t res_op,
	output issue_pkg::word_t res_vj,
	output issue_pkg::word_t res_vk,
	output issue_pkg::rob_tag_t res_qj,
	output issue_pkg::rob_tag_t res_qk,
	output logic issue_ld_busy_dest,
	output logic issue_ld_vj,
	output logic issue_ld_vk,
	output logic issue_ld_qj,
	output logic issue_ld_qk,
	output issue_pkg::station_id_t res_station_id,
	output logic ldstr_write_enable,
	output issue_pkg::word_t ldstr_offset,
	output issue_pkg::rob_tag_t ldstr_qsrc,
	output issue_pkg::rob_tag_t ldstr_qbase,
	output issue_pkg::rob_tag_t ldstr_dest,
	output logic ldstr_vsrc_valid,
	output logic ldstr_vbase_valid,
	output issue_pkg::word_t ldstr_vsrc,
	output issue_pkg::word_t ldstr_vbase,
	output logic rob_write_enable,
	output issue_pkg::opcode_t rob_opcode,
	output issue_pkg::reg_idx_t rob_dest,
	output issue_pkg::word_t rob_value,
	output issue_pkg::reg_idx_t reg_dest,
	output logic ld_reg_busy_dest,
	output issue_pkg::rob_tag_t reg_rob_entry,
	output issue_pkg::reg_idx_t sr1,
	output issue_pkg::reg_idx_t sr2,
	output issue_pkg::rob_tag_t rob_sr1_read_addr,
	output issue_pkg::rob_tag_t rob_sr2_read_addr
);
	import issue_pkg::*;

	word_t op_a_value;
	word_t op_b_value;
	logic op_a_ready;
	logic op_b_ready;
	rob_tag_t op_a_tag;
	rob_tag_t op_b_tag;
	logic mispredict;
	word_t pc_target;
	logic bubble;

	// ROB lookup follows the rename entries of the selected registers
	assign rob_sr1_read_addr = sr1_rob_entry;
	assign rob_sr2_read_addr = sr2_rob_entry;

	operand_select operand_select_i (.*);

	branch_control branch_control_i (.*);

	issue_dispatch issue_dispatch_i (.*);

endmodule

`default_nettype wire

// ==== bench/issue_control_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control_asserts
(
	input wire logic clk,
	input wire logic rst_n,
	input wire issue_pkg::instr_t instr,
	input wire logic instr_is_new,
	input wire issue_pkg::word_t curr_pc,
	input wire logic predict_bit,
	input wire logic btb_hit,
	input wire logic btb_predict,
	input wire logic sr1_busy,
	input wire logic sr2_busy,
	input wire issue_pkg::word_t sr1_data,
	input wire issue_pkg::word_t sr2_data,
	input wire issue_pkg::rob_tag_t sr1_rob_entry,
	input wire issue_pkg::rob_tag_t sr2_rob_entry,
	input wire issue_pkg::word_t rob_sr1_value,
	input wire issue_pkg::word_t rob_sr2_value,
	input wire logic rob_sr1_valid,
	input wire logic rob_sr2_valid,
	input wire logic cdb_valid,
	input wire issue_pkg::rob_tag_t cdb_tag,
	input wire issue_pkg::word_t cdb_data,
	input wire logic rob_full,
	input wire logic ldstr_full,
	input wire logic [issue_pkg::num_alu_rs-1:0] alu_rs_busy,
	input wire issue_pkg::rob_tag_t rob_addr,
	input wire logic stall,
	input wire logic pcmux_sel,
	input wire issue_pkg::word_t br_pc,
	input wire issue_pkg::opcode_t res_op,
	input wire issue_pkg::word_t res_vj,
	input wire issue_pkg::word_t res_vk,
	input wire issue_pkg::rob_tag_t res_qj,
	input wire issue_pkg::rob_tag_t res_qk,
	input wire logic issue_ld_busy_dest,
	input wire logic issue_ld_vj,
	input wire logic issue_ld_vk,
	input wire logic issue_ld_qj,
	input wire logic issue_ld_qk,
	input wire issue_pkg::station_id_t res_station_id,
	input wire logic ldstr_write_enable,
	input wire issue_pkg::word_t ldstr_offset,
	input wire issue_pkg::rob_tag_t ldstr_qsrc,
	input wire issue_pkg::rob_tag_t ldstr_qbase,
	input wire issue_pkg::rob_tag_t ldstr_dest,
	input wire logic ldstr_vsrc_valid,
	input wire logic ldstr_vbase_valid,
	input wire issue_pkg::word_t ldstr_vsrc,
	input wire issue_pkg::word_t ldstr_vbase,
	input wire logic rob_write_enable,
	input wire issue_pkg::opcode_t rob_opcode,
	input wire issue_pkg::reg_idx_t rob_dest,
	input wire issue_pkg::word_t rob_value,
	input wire issue_pkg::reg_idx_t reg_dest,
	input wire logic ld_reg_busy_dest,
	input wire issue_pkg::rob_tag_t reg_rob_entry,
	input wire issue_pkg::reg_idx_t sr1,
	input wire issue_pkg::reg_idx_t sr2,
	input wire issue_pkg::rob_tag_t rob_sr1_read_addr,
	input wire issue_pkg::rob_tag_t rob_sr2_read_addr
);
	import issue_pkg::*;

	int errors = 0;  // Polled by the testbench
	opcode_t opc;
	logic is_alu;
	logic is_ldst;
	logic is_store;
	logic is_jump;
	logic has_dest;
	logic a_rdy;
	logic b_rdy;
	logic vk_known;
	logic exp_stall;
	logic exp_mis;
	logic issue;
	logic writes;
	logic redirect_seen;
	word_t a_val;
	word_t b_val;
	word_t exp_vk;
	word_t exp_off;
	word_t off9;
	word_t off11;
	word_t exp_br;
	reg_idx_t exp_sr2;
	station_id_t free_rs;

	// One quiet cycle follows every redirect
	always_ff @(posedge clk)
		redirect_seen <= rst_n && pcmux_sel;

	always_comb
	begin
		opc = instr.r.opcode;
		is_alu = opc inside {op_add, op_and, op_not, op_shf};
		is_ldst = opc inside {op_ldr, op_ldb, op_str, op_stb};
		is_store = opc inside {op_str, op_stb};
		is_jump = (opc == op_jmp) || (opc == op_jsr);
		has_dest = is_alu || opc == op_ldr || opc == op_ldb;
		exp_sr2 = is_store ? instr.r.dr : instr.r.sr2;
		// Register file first, then CDB, then ROB
		a_rdy = !sr1_busy || (cdb_valid && cdb_tag == sr1_rob_entry) || rob_sr1_valid;
		b_rdy = !sr2_busy || (cdb_valid && cdb_tag == sr2_rob_entry) || rob_sr2_valid;
		a_val = !sr1_busy ? sr1_data :
			(cdb_valid && cdb_tag == sr1_rob_entry) ? cdb_data : rob_sr1_value;
		b_val = !sr2_busy ? sr2_data :
			(cdb_valid && cdb_tag == sr2_rob_entry) ? cdb_data : rob_sr2_value;
		vk_known = instr.r.imm_flag || opc == op_shf || b_rdy;
		exp_vk = (instr.r.imm_flag || opc == op_shf) ? {{11{instr[4]}}, instr[4:0]} : b_val;
		exp_off = (opc == op_ldb || opc == op_stb) ? {{10{instr[5]}}, instr[5:0]} :
			{{9{instr[5]}}, instr[5:0], 1'b0};
		off9 = {{6{instr[8]}}, instr[8:0], 1'b0};
		off11 = {{4{instr[10]}}, instr[10:0], 1'b0};
		exp_br = predict_bit ? curr_pc + off9 : curr_pc;
		exp_mis = btb_hit ? (predict_bit != btb_predict) : predict_bit;
		if (alu_rs_busy[0] == 1'b0)
			free_rs = 2'd0;
		else if (alu_rs_busy[1] == 1'b0)
			free_rs = 2'd1;
		else
			free_rs = 2'd2;
		exp_stall = instr_is_new && !redirect_seen && (rob_full ||
			(is_alu && (&alu_rs_busy)) || (is_ldst && ldstr_full) ||
			((opc == op_jmp || (opc == op_jsr && !instr[11])) && !a_rdy));
		issue = instr_is_new && !redirect_seen && !exp_stall;
		writes = rob_write_enable || ldstr_write_enable || issue_ld_busy_dest ||
			ld_reg_busy_dest;
	end

	a_idle: assert property (@(posedge clk) !instr_is_new |-> !writes && !stall && !pcmux_sel)
	else
	begin
		$error("Idle cycle shows a write, a stall or a redirect");
		errors++;
	end

	a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == exp_stall)
	else
	begin
		$error("Mismatch stall exp %h got %h", exp_stall, stall);
		errors++;
	end

	a_stall_quiet: assert property (@(posedge clk) stall |-> !writes && !pcmux_sel)
	else
	begin
		$error("Stalled cycle shows a write or a redirect");
		errors++;
	end

	// Fetch bubble behind every redirect
	a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		pcmux_sel |=> !writes && !stall && !pcmux_sel)
	else
	begin
		$error("Bubble cycle after a redirect is not quiet");
		errors++;
	end

	a_sr: assert property (@(posedge clk) sr1 == instr.r.sr1 && sr2 == exp_sr2)
	else
	begin
		$error("Mismatch sr1 exp %h got %h sr2 exp %h got %h", instr.r.sr1, sr1, exp_sr2, sr2);
		errors++;
	end

	a_rob_read: assert property (@(posedge clk)
		rob_sr1_read_addr == sr1_rob_entry && rob_sr2_read_addr == sr2_rob_entry)
	else
	begin
		$error("Mismatch rob_sr1_read_addr exp %h got %h rob_sr2_read_addr exp %h got %h",
			sr1_rob_entry, rob_sr1_read_addr, sr2_rob_entry, rob_sr2_read_addr);
		errors++;
	end

	a_alu_rs: assert property (@(posedge clk) disable iff (!rst_n) issue && is_alu |->
		issue_ld_busy_dest && res_station_id == free_rs && res_op == opc)
	else
	begin
		$error("Mismatch res_station_id exp %h got %h res_op exp %h got %h",
			free_rs, res_station_id, opc, res_op);
		errors++;
	end

	a_alu_a: assert property (@(posedge clk) disable iff (!rst_n) issue && is_alu |->
		issue_ld_vj == a_rdy && issue_ld_qj == !a_rdy &&
		(a_rdy ? res_vj == a_val : res_qj == sr1_rob_entry))
	else
	begin
		$error("Mismatch res_vj exp %h got %h res_qj exp %h got %h",
			a_val, res_vj, sr1_rob_entry, res_qj);
		errors++;
	end

	a_alu_b: assert property (@(posedge clk) disable iff (!rst_n) issue && is_alu |->
		issue_ld_vk == vk_known && issue_ld_qk == !vk_known &&
		(vk_known ? res_vk == exp_vk : res_qk == sr2_rob_entry))
	else
	begin
		$error("Mismatch res_vk exp %h got %h res_qk exp %h got %h",
			exp_vk, res_vk, sr2_rob_entry, res_qk);
		errors++;
	end

	a_ldst: assert property (@(posedge clk) disable iff (!rst_n) issue && is_ldst |->
		ldstr_write_enable && ldstr_offset == exp_off &&
		ldstr_dest == (is_store ? 3'd0 : rob_addr))
	else
	begin
		$error("Mismatch ldstr_offset exp %h got %h ldstr_dest got %h",
			exp_off, ldstr_offset, ldstr_dest);
		errors++;
	end

	a_ldst_ops: assert property (@(posedge clk) disable iff (!rst_n) issue && is_ldst |->
		ldstr_vbase_valid == a_rdy &&
		(a_rdy ? ldstr_vbase == a_val : ldstr_qbase == sr1_rob_entry) &&
		(!is_store || (ldstr_vsrc_valid == b_rdy &&
		(b_rdy ? ldstr_vsrc == b_val : ldstr_qsrc == sr2_rob_entry))))
	else
	begin
		$error("Mismatch ldstr_vbase exp %h got %h ldstr_vsrc exp %h got %h",
			a_val, ldstr_vbase, b_val, ldstr_vsrc);
		errors++;
	end

	a_br: assert property (@(posedge clk) disable iff (!rst_n) issue && opc == op_br |->
		rob_write_enable && pcmux_sel == exp_mis && rob_value == off9 && br_pc == exp_br)
	else
	begin
		$error("Mismatch br_pc exp %h got %h rob_value exp %h got %h",
			exp_br, br_pc, off9, rob_value);
		errors++;
	end

	a_rename: assert property (@(posedge clk) disable iff (!rst_n) issue && has_dest |->
		rob_write_enable && rob_opcode == opc && rob_dest == instr.r.dr &&
		ld_reg_busy_dest && reg_dest == instr.r.dr && reg_rob_entry == rob_addr)
	else
	begin
		$error("Mismatch reg_dest exp %h got %h reg_rob_entry exp %h got %h",
			instr.r.dr, reg_dest, rob_addr, reg_rob_entry);
		errors++;
	end

	a_link: assert property (@(posedge clk) disable iff (!rst_n) issue && opc == op_jsr |->
		rob_write_enable && rob_opcode == opc && rob_dest == link_reg &&
		reg_dest == link_reg && ld_reg_busy_dest && reg_rob_entry == rob_addr &&
		rob_value == curr_pc)
	else
	begin
		$error("Mismatch rob_value exp %h got %h", curr_pc, rob_value);
		errors++;
	end

	a_jump: assert property (@(posedge clk) disable iff (!rst_n) issue && is_jump |->
		pcmux_sel && (opc != op_jmp || !writes) &&
		br_pc == ((opc == op_jsr && instr[11]) ? curr_pc + off11 : a_val))
	else
	begin
		$error("Mismatch br_pc got %h", br_pc);
		errors++;
	end

endmodule

bind issue_control issue_control_asserts asserts_i (.*);

`default_nettype wire

// ==== bench/tb_issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_issue_control;
	import issue_pkg::*;

	localparam int random_cycles = 2000;
	localparam int cycle_limit = 2500;  // Reset, random phase and directed branches

	logic clk;
	logic rst_n;
	logic [15:0] instr;
	logic instr_is_new;
	word_t curr_pc;
	logic predict_bit;
	logic btb_hit;
	logic btb_predict;
	logic sr1_busy;
	logic sr2_busy;
	word_t sr1_data;
	word_t sr2_data;
	rob_tag_t sr1_rob_entry;
	rob_tag_t sr2_rob_entry;
	word_t rob_sr1_value;
	word_t rob_sr2_value;
	logic rob_sr1_valid;
	logic rob_sr2_valid;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	word_t cdb_data;
	logic rob_full;
	logic ldstr_full;
	logic [num_alu_rs-1:0] alu_rs_busy;
	rob_tag_t rob_addr;
	logic stall;
	integer seed;
	int cycles;

	issue_control issue_control_i
	(
		.clk, .rst_n, .instr, .instr_is_new, .curr_pc, .predict_bit, .btb_hit, .btb_predict,
		.sr1_busy, .sr2_busy, .sr1_data, .sr2_data, .sr1_rob_entry, .sr2_rob_entry,
		.rob_sr1_value, .rob_sr2_value, .rob_sr1_valid, .rob_sr2_valid,
		.cdb_valid, .cdb_tag, .cdb_data, .rob_full, .ldstr_full, .alu_rs_busy, .rob_addr,
		.stall, .pcmux_sel(),
		.br_pc(), .res_op(), .res_vj(), .res_vk(), .res_qj(), .res_qk(),
		.issue_ld_busy_dest(), .issue_ld_vj(), .issue_ld_vk(), .issue_ld_qj(), .issue_ld_qk(),
		.res_station_id(), .ldstr_write_enable(), .ldstr_offset(), .ldstr_qsrc(),
		.ldstr_qbase(), .ldstr_dest(), .ldstr_vsrc_valid(), .ldstr_vbase_valid(),
		.ldstr_vsrc(), .ldstr_vbase(), .rob_write_enable(), .rob_opcode(), .rob_dest(),
		.rob_value(), .reg_dest(), .ld_reg_busy_dest(), .reg_rob_entry(),
		.sr1(), .sr2(), .rob_sr1_read_addr(), .rob_sr2_read_addr()
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Run stopped");
	endtask

	// Weighted toward ALU ops and branches
	function automatic logic [3:0] pick_opcode(input logic [3:0] sel);
		case (sel)
			4'd0, 4'd1: pick_opcode = op_add;
			4'd2, 4'd3: pick_opcode = op_and;
			4'd4: pick_opcode = op_not;
			4'd5: pick_opcode = op_shf;
			4'd6, 4'd7: pick_opcode = op_ldr;
			4'd8: pick_opcode = op_ldb;
			4'd9: pick_opcode = op_str;
			4'd10: pick_opcode = op_stb;
			4'd11, 4'd12: pick_opcode = op_br;
			4'd13: pick_opcode = op_jmp;
			default: pick_opcode = op_jsr;
		endcase
	endfunction

	task automatic quiet_inputs();
		instr = 16'h0;
		instr_is_new = 1'b0;
		{predict_bit, btb_hit, btb_predict} = 3'b000;
		{sr1_busy, sr2_busy, rob_sr1_valid, rob_sr2_valid, cdb_valid} = 5'b00000;
		{rob_full, ldstr_full} = 2'b00;
		alu_rs_busy = '0;
		sr1_data = 16'h1234;
		sr2_data = 16'h5678;
		{sr1_rob_entry, sr2_rob_entry, cdb_tag, rob_addr} = 12'h321;
		{rob_sr1_value, rob_sr2_value, cdb_data} = {16'h0aa0, 16'h0bb0, 16'h0cc0};
		curr_pc = 16'h3000;
	endtask

	task automatic drive_random();
		logic [31:0] r;
		r = $random(seed);
		instr = {pick_opcode(r[3:0]), r[15:4]};
		instr_is_new = (r[18:16] != 3'd0);
		curr_pc = {r[31:19], 3'b000};
		r = $random(seed);
		{predict_bit, btb_hit, btb_predict} = r[2:0];
		{sr1_busy, sr2_busy, rob_sr1_valid, rob_sr2_valid, cdb_valid} = r[7:3];
		rob_full = (r[10:8] == 3'd0);
		ldstr_full = (r[13:11] == 3'd0);
		alu_rs_busy = r[16:14];
		{sr1_rob_entry, sr2_rob_entry, rob_addr} = r[25:17];
		cdb_tag = r[26] ? sr1_rob_entry : r[29:27];  // Frequent CDB hits on sr1
		r = $random(seed);
		{sr1_data, sr2_data} = r;
		r = $random(seed);
		{rob_sr1_value, rob_sr2_value} = r;
		r = $random(seed);
		cdb_data = r[15:0];
	endtask

	// One branch kind, held until it issues, then its bubble
	task automatic issue_branch(input logic [15:0] word, input logic [2:0] pred,
		input logic base_busy);
		@(negedge clk);
		quiet_inputs();
		instr = word;
		instr_is_new = 1'b1;
		{predict_bit, btb_hit, btb_predict} = pred;
		sr1_busy = base_busy;
		@(posedge clk);
		while (stall)
		begin
			@(negedge clk);
			rob_sr1_valid = 1'b1;  // Base value arrives in the ROB
			@(posedge clk);
		end
		@(negedge clk);
		@(negedge clk);
		instr_is_new = 1'b0;
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
			abort_run("Timeout: cycle limit reached");
	end

	always @(negedge clk)
		if (issue_control_i.asserts_i.errors != 0)
			abort_run("Checker assertion failed");

	initial
	begin
		seed = 32'hc6e5;
		cycles = 0;
		rst_n = 1'b0;
		quiet_inputs();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);
		for (int i = 0; i < random_cycles; i++)
		begin
			drive_random();
			@(negedge clk);
		end
		issue_branch({4'b0000, 3'b111, 9'h1f3}, 3'b100, 1'b0);  // BR, no hit, mispredict
		issue_branch({4'b0000, 3'b010, 9'h024}, 3'b111, 1'b0);  // BR, hit, agrees
		issue_branch({4'b1100, 3'b000, 3'b010, 6'h00}, 3'b000, 1'b0);
		issue_branch({4'b1100, 3'b000, 3'b101, 6'h00}, 3'b000, 1'b1);
		issue_branch({4'b0100, 1'b1, 11'h7f0}, 3'b000, 1'b0);  // JSR
		issue_branch({4'b0100, 3'b000, 3'b011, 6'h00}, 3'b000, 1'b1);  // JSRR, base pending
		repeat (2) @(negedge clk);
		if (issue_control_i.asserts_i.errors == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			abort_run("Checker reported errors");
	end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/issue_pkg.sv
verilog/operand_select.sv
verilog/branch_control.sv
verilog/issue_dispatch.sv
verilog/issue_control.sv
bench/issue_control_asserts.sv
bench/tb_issue_control.sv

// ==== Makefile ====
TOP = tb_issue_control

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000

clean:
	rm -rf obj_dir
